/* filelist.f */
core_pkg.sv
mem_pkg.sv
fetch_stage.sv
inst_mem.sv
fetch_unit.sv
fetch_unit_properties.sv
fetch_unit_tb.sv

/* fetch_unit_tb.sv */
`timescale 1ns/10ps

module fetch_unit_tb;

    localparam int FREE_WORDS     = 40;
    localparam int STALL_WORDS    = 40;
    localparam int REDIRECTS      = 4;
    localparam int REDIRECT_WORDS = 6;  // Words fetched after each redirect.
    localparam int HOLD_WORDS     = 4;
    localparam int PLANNED_WORDS  = FREE_WORDS + STALL_WORDS + REDIRECTS * REDIRECT_WORDS
                                    + HOLD_WORDS;
    localparam int CYCLE_LIMIT    = 3 * mem_pkg::MEM_LATENCY * PLANNED_WORDS + 200;

    logic                            clk;
    logic                            reset;
    logic [core_pkg::XLEN-1:0]       wb_reg_pc;
    logic                            wb_branch_hazard;
    logic                            stall_flg;
    logic                            load_en;
    logic [mem_pkg::MEM_INDEX_W-1:0] load_addr;
    logic [core_pkg::XLEN-1:0]       load_data;
    logic [core_pkg::XLEN-1:0]       id_reg_pc;
    logic [core_pkg::XLEN-1:0]       id_inst;

    logic [15:0] lfsr_state;
    logic        stall_seen = 1'b0;  // Stall at the last edge.
    logic        run_started = 1'b0;
    int          word_count = 0;
    int          cycle_count = 0;

    fetch_unit uut (
        .clk              (clk),
        .reset            (reset),
        .wb_reg_pc        (wb_reg_pc),
        .wb_branch_hazard (wb_branch_hazard),
        .stall_flg        (stall_flg),
        .load_en          (load_en),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .id_reg_pc        (id_reg_pc),
        .id_inst          (id_inst)
    );

    always #2 clk = ~clk;

    // Sixteen bit Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Count real words taken by decode.
    always @(posedge clk) begin
        stall_seen <= stall_flg;
    end

    always @(negedge clk) begin
        if (!reset && !stall_seen && id_reg_pc != core_pkg::REGPC_NOP) begin
            word_count++;
        end
    end

    always @(posedge clk) begin
        if (run_started) begin
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT) begin
                $display("STATUS: FAIL");
                $fatal(1, "Timeout: the run did not end within %0d cycles.", CYCLE_LIMIT);
            end
        end
    end

    always @(posedge clk) begin
        if (uut.u_properties.check_failed) begin
            $display("STATUS: FAIL");
            $fatal(1, "An assertion on the fetch unit failed.");
        end
    end

    // Reset covers the first two load cycles.
    task automatic load_program();
        logic [31:0] value;
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            draw_bits(32, value);
            @(posedge clk);
            if (i == 1) begin
                reset <= 1'b0;
            end
            load_en   <= 1'b1;
            load_addr <= mem_pkg::MEM_INDEX_W'(i);
            load_data <= value;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_words(input int count);
        int target;
        target = word_count + count;
        while (word_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic random_stalls(input int count);
        int          target;
        logic [31:0] bits;
        target = word_count + count;
        while (word_count < target) begin
            draw_bits(1, bits);
            @(posedge clk);
            stall_flg <= bits[0];
        end
        @(posedge clk);
        stall_flg <= 1'b0;
    endtask

    task automatic pulse_redirect();
        logic [31:0] bits;
        draw_bits(8, bits);
        @(posedge clk);
        wb_branch_hazard <= 1'b1;
        wb_reg_pc        <= {22'd0, bits[7:0], 2'b00}; // Word aligned.
        @(posedge clk);
        wb_branch_hazard <= 1'b0;
    endtask

    task automatic stalled_redirect();
        @(posedge clk);
        stall_flg <= 1'b1;
        repeat (2) @(posedge clk);
        pulse_redirect();
        repeat (4) @(posedge clk);
        stall_flg <= 1'b0;
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        wb_reg_pc        = '0;
        wb_branch_hazard = 1'b0;
        stall_flg        = 1'b0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        lfsr_state       = 16'd65;

        load_program();
        run_started = 1'b1;

        wait_words(FREE_WORDS);
        random_stalls(STALL_WORDS);

        for (int i = 0; i < REDIRECTS; i++) begin
            pulse_redirect();
            wait_words(REDIRECT_WORDS);
        end

        stalled_redirect();
        wait_words(HOLD_WORDS);

        repeat (4) @(posedge clk);
        if (uut.u_properties.check_failed) begin
            $display("STATUS: FAIL");
            $fatal(1, "An assertion on the fetch unit failed.");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* fetch_unit_properties.sv */
`timescale 1ns/10ps

module fetch_unit_properties (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::XLEN-1:0]       wb_reg_pc,
    input  logic                            wb_branch_hazard,
    input  logic                            stall_flg,
    input  logic                            load_en,
    input  logic [mem_pkg::MEM_INDEX_W-1:0] load_addr,
    input  logic [core_pkg::XLEN-1:0]       load_data,
    input  logic                            mem_start,
    input  logic                            mem_ready,
    input  logic                            mem_data_valid,
    input  logic                            fetch_state,
    input  logic [core_pkg::XLEN-1:0]       id_reg_pc,
    input  logic [core_pkg::XLEN-1:0]       id_inst
);

    logic [core_pkg::XLEN-1:0] shadow [0:mem_pkg::MEM_WORDS-1]; // Copy of the loaded program.
    logic [core_pkg::XLEN-1:0] shadow_word;
    logic                      new_word;

    logic                      reset_q = 1'b0;
    logic                      stall_q;
    logic                      hazard_q;  // Unstalled redirect at the last edge.
    logic [core_pkg::XLEN-1:0] pc_q;
    logic [core_pkg::XLEN-1:0] inst_q;
    logic                      have_last;
    logic [core_pkg::XLEN-1:0] last_pc;
    logic                      redir_pending;
    logic [core_pkg::XLEN-1:0] redir_target;
    logic                      check_failed = 1'b0;

    assign shadow_word = shadow[id_reg_pc[mem_pkg::MEM_INDEX_W+1:2]];

    // Decode just took a real word.
    assign new_word = !stall_q && (id_reg_pc != core_pkg::REGPC_NOP);

    always_ff @(posedge clk) begin
        if (load_en) begin
            shadow[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        reset_q <= reset;
        pc_q    <= id_reg_pc;
        inst_q  <= id_inst;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_q       <= 1'b0;
            hazard_q      <= 1'b0;
            have_last     <= 1'b0;
            last_pc       <= '0;
            redir_pending <= 1'b0;
            redir_target  <= '0;
        end else begin
            stall_q  <= stall_flg;
            hazard_q <= wb_branch_hazard && !stall_flg;
            if (new_word) begin
                have_last <= 1'b1;
                last_pc   <= id_reg_pc;
            end
            if (wb_branch_hazard) begin
                redir_pending <= 1'b1;
                redir_target  <= wb_reg_pc;
            end else if (new_word) begin
                redir_pending <= 1'b0;
            end
        end
    end

    content_check: assert property (@(posedge clk) disable iff (reset)
        (id_reg_pc != core_pkg::REGPC_NOP) |-> (id_inst == shadow_word))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED content_check: expected %h, actual %h",
               $sampled(shadow_word), $sampled(id_inst));
    end

    order_check: assert property (@(posedge clk) disable iff (reset)
        (new_word && have_last && !redir_pending) |-> (id_reg_pc == last_pc + 32'd4))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED order_check: expected %h, actual %h",
               $sampled(last_pc) + 32'd4, $sampled(id_reg_pc));
    end

    bubble_check: assert property (@(posedge clk) disable iff (reset)
        hazard_q |-> (id_reg_pc == core_pkg::REGPC_NOP) && (id_inst == core_pkg::INST_NOP))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED bubble_check: expected %h, actual %h",
               core_pkg::REGPC_NOP, $sampled(id_reg_pc));
    end

    target_check: assert property (@(posedge clk) disable iff (reset)
        (new_word && redir_pending) |-> (id_reg_pc == redir_target))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED target_check: expected %h, actual %h",
               $sampled(redir_target), $sampled(id_reg_pc));
    end

    stall_check: assert property (@(posedge clk) disable iff (reset)
        stall_q |-> (id_reg_pc == pc_q) && (id_inst == inst_q))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED stall_check: expected %h/%h, actual %h/%h",
               $sampled(pc_q), $sampled(inst_q), $sampled(id_reg_pc), $sampled(id_inst));
    end

    reset_check: assert property (@(posedge clk)
        reset_q |-> (id_reg_pc == core_pkg::REGPC_NOP) && (id_inst == core_pkg::INST_NOP)
                    && (fetch_state == core_pkg::STATE_WAIT_READY))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED reset_check: expected %h/%h, actual %h/%h",
               core_pkg::REGPC_NOP, core_pkg::INST_NOP, $sampled(id_reg_pc), $sampled(id_inst));
    end

    first_word_check: assert property (@(posedge clk) disable iff (reset)
        (new_word && !have_last && !redir_pending) |-> (id_reg_pc == '0))
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED first_word_check: expected %h, actual %h",
               32'h0, $sampled(id_reg_pc));
    end

    // Fixed read latency of the memory.
    latency_check: assert property (@(posedge clk) disable iff (reset)
        (mem_start && mem_ready) |-> ##(mem_pkg::MEM_LATENCY) mem_data_valid)
    else begin
        check_failed = 1'b1;
        $error("CHECK FAILED latency_check: expected %b, actual %b", 1'b1, 1'b0);
    end

endmodule

bind fetch_unit fetch_unit_properties u_properties (
    .clk              (clk),
    .reset            (reset),
    .wb_reg_pc        (wb_reg_pc),
    .wb_branch_hazard (wb_branch_hazard),
    .stall_flg        (stall_flg),
    .load_en          (load_en),
    .load_addr        (load_addr),
    .load_data        (load_data),
    .mem_start        (mem_start),
    .mem_ready        (mem_ready),
    .mem_data_valid   (mem_data_valid),
    .fetch_state      (u_fetch_stage.state),
    .id_reg_pc        (id_reg_pc),
    .id_inst          (id_inst)
);

/* fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                            clk,
    input  logic                            reset,

    input  logic [core_pkg::XLEN-1:0]       wb_reg_pc,
    input  logic                            wb_branch_hazard,
    input  logic                            stall_flg,

    input  logic                            load_en,
    input  logic [mem_pkg::MEM_INDEX_W-1:0] load_addr,
    input  logic [core_pkg::XLEN-1:0]       load_data,

    output logic [core_pkg::XLEN-1:0]       id_reg_pc,
    output logic [core_pkg::XLEN-1:0]       id_inst
);

    // Fetch to memory request path.
    logic                      mem_start;
    logic                      mem_ready;
    logic [core_pkg::XLEN-1:0] mem_addr;
    logic [core_pkg::XLEN-1:0] mem_data;
    logic                      mem_data_valid;

    fetch_stage u_fetch_stage (
        .clk              (clk),
        .reset            (reset),
        .wb_reg_pc        (wb_reg_pc),
        .wb_branch_hazard (wb_branch_hazard),
        .stall_flg        (stall_flg),
        .id_reg_pc        (id_reg_pc),
        .id_inst          (id_inst),
        .mem_start        (mem_start),
        .mem_ready        (mem_ready),
        .mem_addr         (mem_addr),
        .mem_data         (mem_data),
        .mem_data_valid   (mem_data_valid)
    );

    inst_mem u_inst_mem (
        .clk            (clk),
        .reset          (reset),
        .mem_start      (mem_start),
        .mem_addr       (mem_addr),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data)
    );

endmodule

/* inst_mem.sv */
`timescale 1ns/10ps

module inst_mem (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           mem_start,
    input  logic [core_pkg::XLEN-1:0]      mem_addr,
    output logic                           mem_ready,
    output logic [core_pkg::XLEN-1:0]      mem_data,
    output logic                           mem_data_valid,

    input  logic                           load_en,
    input  logic [mem_pkg::MEM_INDEX_W-1:0] load_addr,
    input  logic [core_pkg::XLEN-1:0]      load_data
);

    logic [core_pkg::XLEN-1:0]       words [0:mem_pkg::MEM_WORDS-1];

    logic [mem_pkg::MEM_INDEX_W-1:0] rd_index;
    logic [core_pkg::XLEN-1:0]       rd_data;
    logic [mem_pkg::MEM_CNT_W-1:0]   cnt;      // Cycles left to data_valid.
    logic                            accept;

    // Idle or in the valid cycle, and the loader is quiet.
    assign mem_ready = (cnt <= mem_pkg::MEM_CNT_W'(1)) && !load_en;

    assign accept = mem_start && mem_ready;

    assign mem_data_valid = (cnt == mem_pkg::MEM_CNT_W'(1));
    assign mem_data       = rd_data;

    // Program loader port.
    always_ff @(posedge clk) begin
        if (load_en) begin
            words[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= mem_pkg::MEM_CNT_W'(mem_pkg::MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - mem_pkg::MEM_CNT_W'(1);
        end
    end

    // Address captured on acceptance, array read one cycle before valid.
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_index <= mem_addr[mem_pkg::MEM_INDEX_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (cnt == mem_pkg::MEM_CNT_W'(2)) begin
            rd_data <= words[rd_index];
        end
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      reset,

    input  logic [core_pkg::XLEN-1:0] wb_reg_pc,
    input  logic                      wb_branch_hazard,
    input  logic                      stall_flg,

    output logic [core_pkg::XLEN-1:0] id_reg_pc,
    output logic [core_pkg::XLEN-1:0] id_inst,

    output logic                      mem_start,
    input  logic                      mem_ready,
    output logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic [core_pkg::XLEN-1:0] mem_data,
    input  logic                      mem_data_valid
);

    logic                      state;
    logic [core_pkg::XLEN-1:0] pc;         // Pc of the word in flight.
    logic                      is_fetched; // A word waits for the stall to end.

    logic [core_pkg::XLEN-1:0] saved_pc;
    logic [core_pkg::XLEN-1:0] saved_inst;

    logic                      word_arrive;
    logic                      word_held;
    logic                      slot_free;
    logic [core_pkg::XLEN-1:0] next_pc;
    logic [core_pkg::XLEN-1:0] out_pc;
    logic [core_pkg::XLEN-1:0] out_inst;

    // New word from memory, not yet taken.
    assign word_arrive = (state == core_pkg::STATE_WAIT_VALID) && !is_fetched
                         && mem_data_valid;
    assign word_held   = (state == core_pkg::STATE_WAIT_VALID) && is_fetched;

    // A new request may go out once the previous word has left for decode.
    // A redirect frees the slot at once since its word gets dropped.
    assign slot_free = (state == core_pkg::STATE_WAIT_READY)
                       || wb_branch_hazard
                       || ((word_arrive || word_held) && !stall_flg);

    assign mem_start = slot_free && mem_ready;

    always_comb begin
        if (wb_branch_hazard) begin
            next_pc = wb_reg_pc;
        end else if (word_arrive) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    assign mem_addr = next_pc;

    // Word or bubble for decode.
    always_comb begin
        if (wb_branch_hazard) begin
            out_pc   = core_pkg::REGPC_NOP;
            out_inst = core_pkg::INST_NOP;
        end else if (word_arrive) begin
            out_pc   = pc;
            out_inst = mem_data;
        end else if (word_held) begin
            out_pc   = saved_pc;
            out_inst = saved_inst;
        end else begin
            out_pc   = core_pkg::REGPC_NOP;
            out_inst = core_pkg::INST_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_reg_pc <= core_pkg::REGPC_NOP;
            id_inst   <= core_pkg::INST_NOP;
        end else if (!stall_flg) begin
            id_reg_pc <= out_pc;
            id_inst   <= out_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            is_fetched <= 1'b0;
        end else if (wb_branch_hazard) begin
            is_fetched <= 1'b0; // Saved word is wrong path.
        end else if (word_arrive && stall_flg) begin
            is_fetched <= 1'b1;
        end else if (word_held && !stall_flg) begin
            is_fetched <= 1'b0;
        end
    end

    // Hold the word that arrives while decode stalls.
    always_ff @(posedge clk) begin
        if (word_arrive && stall_flg) begin
            saved_pc   <= pc;
            saved_inst <= mem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::STATE_WAIT_READY;
        end else begin
            case (state)
                core_pkg::STATE_WAIT_READY: begin
                    if (mem_start) begin
                        state <= core_pkg::STATE_WAIT_VALID;
                    end
                end
                default: begin
                    // Back off when memory cannot take the next request.
                    if (slot_free && !mem_ready) begin
                        state <= core_pkg::STATE_WAIT_READY;
                    end
                end
            endcase
        end
    end

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // Instruction memory geometry.
    localparam int MEM_WORDS   = 256;
    localparam int MEM_INDEX_W = 8; // Word index, taken from address bits 9..2.

    // Cycles from accepted start to data_valid, at least 2.
    localparam int MEM_LATENCY = 2;

    // Latency counter width.
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

endpackage

/* core_pkg.sv */
package core_pkg;

    // Width of pc and instruction words.
    localparam int XLEN = 32;

    // Fetch controller states.
    localparam logic STATE_WAIT_READY = 1'b0; // Waiting to issue a request.
    localparam logic STATE_WAIT_VALID = 1'b1; // Request in flight or word held.

    // Bubble markers seen by decode.
    localparam logic [XLEN-1:0] REGPC_NOP = {XLEN{1'b1}};
    localparam logic [XLEN-1:0] INST_NOP  = 32'h0000_0013; // addi x0, x0, 0.

endpackage
